// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_decode_stage
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported errors"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: ctrl_decoder.sv
module ctrl_decoder
    import rv_decode_pkg::*;
(
    input  logic [6:0]   opcode_i,
    input  logic [2:0]   funct3_i,
    input  logic [6:0]   funct7_i,
    output decode_ctrl_t ctrl_o,
    output imm_fmt_e     imm_fmt_o
);

    always_comb begin
        // Unknown opcodes fall through with everything inactive
        ctrl_o    = '0;
        imm_fmt_o = IMM_NONE;

        case (opcode_i)
            OPC_LUI: begin
                ctrl_o.en_alu    = 1'b1;
                ctrl_o.op_alu    = ALU_LUI;
                ctrl_o.reg_write = 1'b1;
                imm_fmt_o        = IMM_U;
            end

            OPC_AUIPC: begin
                ctrl_o.en_alu    = 1'b1;
                ctrl_o.op_alu    = ALU_AUIPC;
                ctrl_o.reg_write = 1'b1;
                imm_fmt_o        = IMM_U;
            end

            OPC_JAL: begin
                ctrl_o.en_alu    = 1'b1;
                ctrl_o.op_alu    = ALU_JAL;
                ctrl_o.reg_write = 1'b1;
                imm_fmt_o        = IMM_J;
            end

            // Only funct3 000 is a legal JALR
            OPC_JALR: begin
                if (funct3_i == F3_JALR) begin
                    ctrl_o.en_alu       = 1'b1;
                    ctrl_o.op_alu       = ALU_JALR;
                    ctrl_o.reg_read_rs1 = 1'b1;
                    ctrl_o.reg_write    = 1'b1;
                    imm_fmt_o           = IMM_I;
                end
            end

            // ------------------------------------------------------
            // Branches use the ALU for the compare
            // ------------------------------------------------------
            OPC_BRANCH: begin
                ctrl_o.en_branch    = 1'b1;
                ctrl_o.en_alu       = 1'b1;
                ctrl_o.reg_read_rs1 = 1'b1;
                ctrl_o.reg_read_rs2 = 1'b1;
                imm_fmt_o           = IMM_B;
                case (funct3_i)
                    F3_BEQ: begin
                        ctrl_o.op_alu = ALU_BEQ;
                        ctrl_o.op_bra = BRA_BEQ;
                    end
                    F3_BNE: begin
                        ctrl_o.op_alu = ALU_BNE;
                        ctrl_o.op_bra = BRA_BNE;
                    end
                    F3_BLT: begin
                        ctrl_o.op_alu = ALU_BLT;
                        ctrl_o.op_bra = BRA_BLT;
                    end
                    F3_BGE: begin
                        ctrl_o.op_alu = ALU_BGE;
                        ctrl_o.op_bra = BRA_BGE;
                    end
                    F3_BLTU: begin
                        ctrl_o.op_alu = ALU_BLTU;
                        ctrl_o.op_bra = BRA_BLTU;
                    end
                    F3_BGEU: begin
                        ctrl_o.op_alu = ALU_BGEU;
                        ctrl_o.op_bra = BRA_BGEU;
                    end
                    default: ;
                endcase
            end

            // ------------------------------------------------------
            // Memory access, ALU forms the address
            // ------------------------------------------------------
            OPC_LOAD: begin
                ctrl_o.en_mem       = 1'b1;
                ctrl_o.en_alu       = 1'b1;
                ctrl_o.op_alu       = ALU_MEM;
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.reg_read_rs1 = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                imm_fmt_o           = IMM_I;
                case (funct3_i)
                    F3_LB:   ctrl_o.op_mem = MEM_LB;
                    F3_LH:   ctrl_o.op_mem = MEM_LH;
                    F3_LW:   ctrl_o.op_mem = MEM_LW;
                    F3_LBU:  ctrl_o.op_mem = MEM_LBU;
                    F3_LHU:  ctrl_o.op_mem = MEM_LHU;
                    default: ;
                endcase
            end

            OPC_STORE: begin
                ctrl_o.en_mem       = 1'b1;
                ctrl_o.en_alu       = 1'b1;
                ctrl_o.op_alu       = ALU_MEM;
                ctrl_o.mem_write    = 1'b1;
                ctrl_o.reg_read_rs1 = 1'b1;
                ctrl_o.reg_read_rs2 = 1'b1;
                imm_fmt_o           = IMM_S;
                case (funct3_i)
                    F3_SB:   ctrl_o.op_mem = MEM_SB;
                    F3_SH:   ctrl_o.op_mem = MEM_SH;
                    F3_SW:   ctrl_o.op_mem = MEM_SW;
                    default: ;
                endcase
            end

            // ------------------------------------------------------
            // Integer arithmetic
            // ------------------------------------------------------
            OPC_OP_IMM: begin
                ctrl_o.en_alu       = 1'b1;
                ctrl_o.reg_read_rs1 = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                imm_fmt_o           = IMM_I;
                case (funct3_i)
                    F3_ADD_SUB: ctrl_o.op_alu = ALU_ADDI;
                    F3_SLT:     ctrl_o.op_alu = ALU_SLTI;
                    F3_SLTU:    ctrl_o.op_alu = ALU_SLTIU;
                    F3_XOR:     ctrl_o.op_alu = ALU_XORI;
                    F3_OR:      ctrl_o.op_alu = ALU_ORI;
                    F3_AND:     ctrl_o.op_alu = ALU_ANDI;
                    default:    ;
                endcase
                // Shifts also need a legal funct7, else the I format stays
                case ({funct7_i, funct3_i})
                    {F7_BASE, F3_SLL}: begin
                        ctrl_o.op_alu = ALU_SLLI;
                        imm_fmt_o     = IMM_SHAMT;
                    end
                    {F7_BASE, F3_SRL_SRA}: begin
                        ctrl_o.op_alu = ALU_SRLI;
                        imm_fmt_o     = IMM_SHAMT;
                    end
                    {F7_ALT, F3_SRL_SRA}: begin
                        ctrl_o.op_alu = ALU_SRAI;
                        imm_fmt_o     = IMM_SHAMT;
                    end
                    default: ;
                endcase
            end

            OPC_OP: begin
                ctrl_o.en_alu       = 1'b1;
                ctrl_o.reg_read_rs1 = 1'b1;
                ctrl_o.reg_read_rs2 = 1'b1;
                ctrl_o.reg_write    = 1'b1;
                case ({funct7_i, funct3_i})
                    {F7_BASE,   F3_ADD_SUB}: ctrl_o.op_alu = ALU_ADD;
                    {F7_ALT,    F3_ADD_SUB}: ctrl_o.op_alu = ALU_SUB;
                    {F7_BASE,   F3_SLL}:     ctrl_o.op_alu = ALU_SLL;
                    {F7_BASE,   F3_SLT}:     ctrl_o.op_alu = ALU_SLT;
                    {F7_BASE,   F3_SLTU}:    ctrl_o.op_alu = ALU_SLTU;
                    {F7_BASE,   F3_XOR}:     ctrl_o.op_alu = ALU_XOR;
                    {F7_BASE,   F3_SRL_SRA}: ctrl_o.op_alu = ALU_SRL;
                    {F7_ALT,    F3_SRL_SRA}: ctrl_o.op_alu = ALU_SRA;
                    {F7_BASE,   F3_OR}:      ctrl_o.op_alu = ALU_OR;
                    {F7_BASE,   F3_AND}:     ctrl_o.op_alu = ALU_AND;
                    // M extension
                    {F7_MULDIV, F3_MUL}:     ctrl_o.op_alu = ALU_MUL;
                    {F7_MULDIV, F3_MULH}:    ctrl_o.op_alu = ALU_MULH;
                    {F7_MULDIV, F3_MULHSU}:  ctrl_o.op_alu = ALU_MULHSU;
                    {F7_MULDIV, F3_MULHU}:   ctrl_o.op_alu = ALU_MULHU;
                    {F7_MULDIV, F3_DIV}:     ctrl_o.op_alu = ALU_DIV;
                    {F7_MULDIV, F3_DIVU}:    ctrl_o.op_alu = ALU_DIVU;
                    {F7_MULDIV, F3_REM}:     ctrl_o.op_alu = ALU_REM;
                    {F7_MULDIV, F3_REMU}:    ctrl_o.op_alu = ALU_REMU;
                    default:                 ;
                endcase
            end

            default: ;
        endcase
    end

endmodule

// File: decode_stage.sv
module decode_stage
    import rv_decode_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           instr_valid_i,
    input  instr_t         instr_i,
    output logic           dec_valid_o,
    output decoded_instr_t dec_o
);

    // ----------------------------------------------------------
    // Field split
    // ----------------------------------------------------------
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    reg_addr_t       rd;

    decode_ctrl_t    ctrl;
    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;
    decoded_instr_t  dec_next;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    ctrl_decoder u_ctrl_decoder (
        .opcode_i  (opcode),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .ctrl_o    (ctrl),
        .imm_fmt_o (imm_fmt)
    );

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    // Register addresses go out raw, even when unused
    always_comb begin
        dec_next.ctrl = ctrl;
        dec_next.imm  = imm;
        dec_next.rs1  = rs1;
        dec_next.rs2  = rs2;
        dec_next.rd   = rd;
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end else begin
            dec_valid_o <= instr_valid_i;
            // Record holds between strobes
            if (instr_valid_i) begin
                dec_o <= dec_next;
            end
        end
    end

    // Never both a read and a write on one record
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o |-> !(dec_o.ctrl.mem_read && dec_o.ctrl.mem_write));

    // Branch compare runs in the ALU
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && dec_o.ctrl.en_branch |-> dec_o.ctrl.en_alu);

    // One record per strobe, exactly one cycle later
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        1'b1 |=> (dec_valid_o == $past(instr_valid_i)));

endmodule

// File: files.f
rv_decode_pkg.sv
ctrl_decoder.sv
imm_gen.sv
decode_stage.sv
tb_decode_stage.sv

// File: imm_gen.sv
module imm_gen
    import rv_decode_pkg::*;
(
    input  instr_t          instr_i,
    input  imm_fmt_e        fmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;

    // Bit 31 is the sign for every signed format
    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // Shift amount sits in the rs2 field
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr_i[24:20]};

    always_comb begin
        case (fmt_i)
            IMM_I:     imm_o = imm_i;
            IMM_S:     imm_o = imm_s;
            IMM_B:     imm_o = imm_b;
            IMM_U:     imm_o = imm_u;
            IMM_J:     imm_o = imm_j;
            IMM_SHAMT: imm_o = imm_shamt;
            default:   imm_o = '0;
        endcase
    end

endmodule

// File: rv_decode_pkg.sv
package rv_decode_pkg;

    // ----------------------------------------------------------
    // Widths and basic types
    // ----------------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] instr_t;
    typedef logic [4:0]      reg_addr_t;

    // ----------------------------------------------------------
    // Major opcodes, RV32I base
    // ----------------------------------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Funct3 for jump and branches
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    // Funct3 for loads and stores
    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    // Funct3 for OP and OP_IMM arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct3 for the M extension, funct7 is F7_MULDIV
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [2:0] F3_MULH    = 3'b001;
    localparam logic [2:0] F3_MULHSU  = 3'b010;
    localparam logic [2:0] F3_MULHU   = 3'b011;
    localparam logic [2:0] F3_DIV     = 3'b100;
    localparam logic [2:0] F3_DIVU    = 3'b101;
    localparam logic [2:0] F3_REM     = 3'b110;
    localparam logic [2:0] F3_REMU    = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    // ----------------------------------------------------------
    // Operation encodings
    // ----------------------------------------------------------
    typedef enum logic [5:0] {
        ALU_NONE = 6'd0,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_MEM,
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI, ALU_ANDI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        BRA_NONE = 3'd0,
        BRA_BEQ, BRA_BNE, BRA_BLT, BRA_BGE, BRA_BLTU, BRA_BGEU
    } bra_op_e;

    // Nine codes, so one bit wider than the branch field
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    // ----------------------------------------------------------
    // Decode records
    // ----------------------------------------------------------
    typedef struct packed {
        logic    en_alu;
        logic    en_branch;
        logic    en_mem;
        alu_op_e op_alu;
        bra_op_e op_bra;
        mem_op_e op_mem;
        logic    mem_read;
        logic    mem_write;
        logic    reg_read_rs1;
        logic    reg_read_rs2;
        logic    reg_write;
    } decode_ctrl_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] imm;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
    } decoded_instr_t;

endpackage

// File: tb_decode_stage.sv
module tb_decode_stage
    import rv_decode_pkg::*;
();

    // Reset, the six tests, then two drain cycles after each test
    localparam int STIM_CYCLES = 3 + 10 + 40 + 40 + 24 + 14 + 303 + 6 * 2;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

    logic           clk;
    logic           rst_n;
    logic           instr_valid;
    instr_t         instr;
    logic           dec_valid;
    decoded_instr_t dec;

    decoded_instr_t expected_q[$];
    decoded_instr_t held_rec = '0;
    logic           strobe_d = 1'b0;
    string          cur_test = "reset";
    int             checks = 0;
    int             errors = 0;
    int             start_errors = 0;
    int             tests = 0;
    int             cycle_count = 0;

    // Base, alternate, M extension, a former crypto code, all ones
    logic [6:0] f7_pool [5] = '{7'h00, 7'h20, 7'h01, 7'h05, 7'h7f};
    // Known opcodes plus the former AI opcode
    logic [6:0] opc_pool [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                  OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, 7'b0001011};

    decode_stage UUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Reference decode
    // ----------------------------------------------------------
    function automatic logic [31:0] sign_extend(input logic [31:0] left_aligned,
                                                input int width);
        logic signed [31:0] v;
        v = left_aligned;
        return v >>> (32 - width);
    endfunction

    function automatic decoded_instr_t ref_decode(input instr_t ins);
        decoded_instr_t r;
        byte            fmt;
        logic [2:0]     f3;
        logic [6:0]     f7;
        f3    = ins[14:12];
        f7    = ins[31:25];
        fmt   = "-";
        r     = '0;
        r.rs1 = ins[19:15];
        r.rs2 = ins[24:20];
        r.rd  = ins[11:7];
        case (ins[6:0])
            OPC_LUI: begin
                fmt           = "U";
                r.ctrl.op_alu = ALU_LUI;
            end
            OPC_AUIPC: begin
                fmt           = "U";
                r.ctrl.op_alu = ALU_AUIPC;
            end
            OPC_JAL: begin
                fmt           = "J";
                r.ctrl.op_alu = ALU_JAL;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    fmt           = "I";
                    r.ctrl.op_alu = ALU_JALR;
                end
            end
            OPC_BRANCH: begin
                fmt              = "B";
                r.ctrl.en_branch = 1'b1;
                case (f3)
                    3'b000: begin
                        r.ctrl.op_bra = BRA_BEQ;
                        r.ctrl.op_alu = ALU_BEQ;
                    end
                    3'b001: begin
                        r.ctrl.op_bra = BRA_BNE;
                        r.ctrl.op_alu = ALU_BNE;
                    end
                    3'b100: begin
                        r.ctrl.op_bra = BRA_BLT;
                        r.ctrl.op_alu = ALU_BLT;
                    end
                    3'b101: begin
                        r.ctrl.op_bra = BRA_BGE;
                        r.ctrl.op_alu = ALU_BGE;
                    end
                    3'b110: begin
                        r.ctrl.op_bra = BRA_BLTU;
                        r.ctrl.op_alu = ALU_BLTU;
                    end
                    3'b111: begin
                        r.ctrl.op_bra = BRA_BGEU;
                        r.ctrl.op_alu = ALU_BGEU;
                    end
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                fmt             = "I";
                r.ctrl.mem_read = 1'b1;
                case (f3)
                    3'b000:  r.ctrl.op_mem = MEM_LB;
                    3'b001:  r.ctrl.op_mem = MEM_LH;
                    3'b010:  r.ctrl.op_mem = MEM_LW;
                    3'b100:  r.ctrl.op_mem = MEM_LBU;
                    3'b101:  r.ctrl.op_mem = MEM_LHU;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                fmt              = "S";
                r.ctrl.mem_write = 1'b1;
                case (f3)
                    3'b000:  r.ctrl.op_mem = MEM_SB;
                    3'b001:  r.ctrl.op_mem = MEM_SH;
                    3'b010:  r.ctrl.op_mem = MEM_SW;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                fmt = "I";
                case (f3)
                    3'b000: r.ctrl.op_alu = ALU_ADDI;
                    3'b010: r.ctrl.op_alu = ALU_SLTI;
                    3'b011: r.ctrl.op_alu = ALU_SLTIU;
                    3'b100: r.ctrl.op_alu = ALU_XORI;
                    3'b110: r.ctrl.op_alu = ALU_ORI;
                    3'b111: r.ctrl.op_alu = ALU_ANDI;
                    default: begin
                        // Shift amount only with a legal funct7
                        if (f3 == 3'b001 && f7 == 7'h00) begin
                            r.ctrl.op_alu = ALU_SLLI;
                            fmt           = "H";
                        end else if (f3 == 3'b101 && f7 == 7'h00) begin
                            r.ctrl.op_alu = ALU_SRLI;
                            fmt           = "H";
                        end else if (f3 == 3'b101 && f7 == 7'h20) begin
                            r.ctrl.op_alu = ALU_SRAI;
                            fmt           = "H";
                        end
                    end
                endcase
            end
            OPC_OP: begin
                fmt = "R";
                case ({f7, f3})
                    10'b0000000_000: r.ctrl.op_alu = ALU_ADD;
                    10'b0100000_000: r.ctrl.op_alu = ALU_SUB;
                    10'b0000000_001: r.ctrl.op_alu = ALU_SLL;
                    10'b0000000_010: r.ctrl.op_alu = ALU_SLT;
                    10'b0000000_011: r.ctrl.op_alu = ALU_SLTU;
                    10'b0000000_100: r.ctrl.op_alu = ALU_XOR;
                    10'b0000000_101: r.ctrl.op_alu = ALU_SRL;
                    10'b0100000_101: r.ctrl.op_alu = ALU_SRA;
                    10'b0000000_110: r.ctrl.op_alu = ALU_OR;
                    10'b0000000_111: r.ctrl.op_alu = ALU_AND;
                    // M operations
                    10'b0000001_000: r.ctrl.op_alu = ALU_MUL;
                    10'b0000001_001: r.ctrl.op_alu = ALU_MULH;
                    10'b0000001_010: r.ctrl.op_alu = ALU_MULHSU;
                    10'b0000001_011: r.ctrl.op_alu = ALU_MULHU;
                    10'b0000001_100: r.ctrl.op_alu = ALU_DIV;
                    10'b0000001_101: r.ctrl.op_alu = ALU_DIVU;
                    10'b0000001_110: r.ctrl.op_alu = ALU_REM;
                    10'b0000001_111: r.ctrl.op_alu = ALU_REMU;
                    default:         ;
                endcase
            end
            default: ;
        endcase
        if (r.ctrl.mem_read || r.ctrl.mem_write) begin
            r.ctrl.en_mem = 1'b1;
            r.ctrl.op_alu = ALU_MEM;
        end
        // Register use follows the instruction format
        if (fmt != "-") begin
            r.ctrl.en_alu       = 1'b1;
            r.ctrl.reg_read_rs1 = fmt inside {"R", "I", "H", "S", "B"};
            r.ctrl.reg_read_rs2 = fmt inside {"R", "S", "B"};
            r.ctrl.reg_write    = fmt inside {"R", "I", "H", "U", "J"};
        end
        case (fmt)
            "I": r.imm = sign_extend({ins[31:20], 20'b0}, 12);
            "S": r.imm = sign_extend({ins[31:25], ins[11:7], 20'b0}, 12);
            "B": r.imm = sign_extend({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'b0}, 13);
            "U": r.imm = {ins[31:12], 12'b0};
            "J": r.imm = sign_extend({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'b0}, 21);
            "H": r.imm = 32'(ins[24:20]);
            default: ;
        endcase
        return r;
    endfunction

    // ----------------------------------------------------------
    // Stimulus and checking helpers
    // ----------------------------------------------------------
    function automatic instr_t random_instr(input logic [6:0] opc, input logic [2:0] f3);
        instr_t ins;
        ins        = $urandom();
        ins[14:12] = f3;
        ins[6:0]   = opc;
        return ins;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic send_instr(input instr_t ins);
        @(posedge clk);
        #10;
        instr_valid = 1'b1;
        instr       = ins;
        expected_q.push_back(ref_decode(ins));
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        start_errors = errors;
    endtask

    // Wait until every record sent in this test has come out
    task automatic finish_test();
        drive_idle();
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        tests++;
        $display("%-14s done, %0d errors", cur_test, errors - start_errors);
    endtask

    always @(posedge clk) begin
        strobe_d <= instr_valid;
    end

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        decoded_instr_t exp_rec;
        if (rst_n) begin
            check_value({cur_test, " valid"}, 128'(strobe_d), 128'(dec_valid));
            if (dec_valid) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("%s: record came out with no instruction pending", cur_test);
                end else begin
                    exp_rec  = expected_q.pop_front();
                    held_rec = exp_rec;
                    check_value(cur_test, 128'(exp_rec), 128'(dec));
                end
            end else begin
                // Zero before the first strobe, last record after it
                check_value({cur_test, " held record"}, 128'(held_rec), 128'(dec));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        instr_t ins;
        void'($urandom(32'hef9a_fd0b));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Quiet first, then four strobes back to back and one alone
        start_test("reset");
        repeat (4) drive_idle();
        for (int k = 0; k < 4; k++) begin
            send_instr(random_instr(OPC_OP, 3'(k)));
        end
        drive_idle();
        send_instr(random_instr(OPC_LUI, 3'b101));
        finish_test();

        start_test("reg_ops");
        for (int f = 0; f < 8; f++) begin
            for (int j = 0; j < 5; j++) begin
                ins        = random_instr(OPC_OP, 3'(f));
                ins[31:25] = f7_pool[j];
                send_instr(ins);
            end
        end
        finish_test();

        start_test("imm_ops");
        for (int f = 0; f < 8; f++) begin
            for (int j = 0; j < 5; j++) begin
                ins        = random_instr(OPC_OP_IMM, 3'(f));
                ins[31:25] = f7_pool[j];
                send_instr(ins);
            end
        end
        finish_test();

        start_test("mem_branch");
        for (int f = 0; f < 8; f++) begin
            send_instr(random_instr(OPC_LOAD, 3'(f)));
            send_instr(random_instr(OPC_STORE, 3'(f)));
            send_instr(random_instr(OPC_BRANCH, 3'(f)));
        end
        finish_test();

        start_test("upper_jump");
        repeat (2) begin
            send_instr(random_instr(OPC_LUI, 3'($urandom)));
            send_instr(random_instr(OPC_AUIPC, 3'($urandom)));
            send_instr(random_instr(OPC_JAL, 3'($urandom)));
        end
        for (int f = 0; f < 8; f++) begin
            send_instr(random_instr(OPC_JALR, 3'(f)));
        end
        finish_test();

        start_test("unknown_sweep");
        send_instr(random_instr(7'b0001011, 3'($urandom)));
        send_instr(random_instr(7'b1110011, 3'($urandom)));
        send_instr(random_instr(7'b0000000, 3'($urandom)));
        repeat (300) begin
            ins = random_instr(opc_pool[$urandom_range(9)], 3'($urandom));
            // Half the time use a funct7 that OP can match
            if ($urandom_range(1) == 1) begin
                ins[31:25] = f7_pool[$urandom_range(2)];
            end
            send_instr(ins);
        end
        finish_test();

        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
